//--- logic/deflate_store_pkg.sv
// Deflate stored-mode definitions

package deflate_store_pkg;

	// ================================================
	// Widths
	// ================================================
	localparam int word_w = 32;            // FIFO and output word width
	localparam int byte_w = 8;             // One data byte
	localparam int size_w = 6;             // Packer field size from 1 to 32 bits

	// ================================================
	// Constants
	// ================================================
	localparam logic [31:0] crc_poly = 32'hEDB88320;  // Reflected CRC32 polynomial
	localparam logic [31:0] crc_init = 32'hFFFFFFFF;  // Start value and final XOR
	localparam logic [1:0] btype_stored = 2'b00;      // BTYPE for an uncompressed block
	localparam int max_stored_len = 65535;            // Largest LEN a stored block can carry

	// Header view of an input word
	// Bits 15:0 carry LEN and bits 23:16 must be zero for a legal stored block
	typedef struct packed {
		logic [6:0]  unused;     // Ignored by the sequencer
		logic        bfinal;     // Last block of the stream
		logic [7:0]  len_hi;     // Length bits above 16 that are flagged as an error
		logic [15:0] len;        // Number of data bytes that follow
	} header_fields_t;

	// One input word seen either as a block header or as four data bytes
	// Byte 0 sits in bits 7:0 and is the first byte of the stream
	typedef union packed {
		header_fields_t              hdr;
		logic [3:0][byte_w-1:0]      bytes;
	} header_word_t;

endpackage

//--- logic/word_fifo.sv
// Synchronous word FIFO

`timescale 1ns/1ps

module word_fifo import deflate_store_pkg::*; #(
	parameter int fifo_depth_log = 9
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wr,
	input  logic [word_w-1:0] din,
	output logic              full,
	input  logic              rd,
	output logic [word_w-1:0] dout,
	output logic              empty
);

	logic [word_w-1:0]         mem [2**fifo_depth_log];  // Storage array
	logic [fifo_depth_log-1:0] wr_ptr;                   // Next slot to write
	logic [fifo_depth_log-1:0] rd_ptr;                   // Next slot to read
	logic [fifo_depth_log:0]   count;                    // Words held with one bit more than the pointers
	logic                      do_wr;
	logic                      do_rd;

	assign do_wr = wr && !full;          // Writes into a full buffer are ignored
	assign do_rd = rd && !empty;
	assign full  = count[fifo_depth_log]; // Top bit alone means count equals depth
	assign empty = (count == '0);

	// Pointers wrap naturally at the power of two depth
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd) count <= count + 1'b1;
			else if (do_rd && !do_wr) count <= count - 1'b1;
		end
	end

	// Memory write and registered read port
	always_ff @(posedge clk) begin
		if (do_wr) mem[wr_ptr] <= din;
		if (do_rd) dout <= mem[rd_ptr];  // Word shows up the cycle after rd
	end

	// Neighbours must respect the flags or words are silently lost
	a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full);
	a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty);

endmodule

//--- logic/crc32_engine.sv
// Byte-wide CRC32

`timescale 1ns/1ps

module crc32_engine import deflate_store_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              crc_valid,
	input  logic [byte_w-1:0] crc_byte,
	output logic [word_w-1:0] crc_value
);

	logic [word_w-1:0] crc_state;  // Running reflected remainder
	logic [word_w-1:0] crc_next;

	// Eight shift steps of the reflected LFSR in one cycle
	always_comb begin
		crc_next = crc_state ^ word_w'(crc_byte);  // Byte enters at the low end
		for (int i = 0; i < byte_w; i++) begin
			if (crc_next[0])
				crc_next = (crc_next >> 1) ^ crc_poly;
			else
				crc_next = crc_next >> 1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			crc_state <= crc_init;
		else if (crc_valid)
			crc_state <= crc_next;  // Visible on crc_value one cycle after the byte
	end

	// Final XOR gives the value that goes into the gzip trailer
	assign crc_value = crc_state ^ crc_init;

endmodule

//--- logic/bit_packer.sv
// LSB-first bit packer

`timescale 1ns/1ps

module bit_packer import deflate_store_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              field_valid,
	input  logic [size_w-1:0] field_size,
	input  logic [word_w-1:0] field_data,
	input  logic              field_last,
	output logic              pk_ready,
	input  logic              out_full,
	output logic              push,
	output logic [word_w-1:0] word
);

	logic [2*word_w-1:0] acc;         // Pending bits with the oldest at bit 0 and zeros above pend
	logic [6:0]          pend;        // Number of valid bits in acc which never exceeds 63
	logic                flushing;    // Set once the last field is taken until all has drained
	logic                take;
	logic [2*word_w-1:0] field_bits;  // Incoming field trimmed and moved above pend

	// At most 31 pending bits plus one 32 bit field always fit the accumulator
	assign pk_ready = (pend < 7'd32) && !flushing && !out_full;
	assign take     = field_valid && pk_ready;

	// A full word goes out first and a partial one only during the final flush
	assign push = !out_full && ((pend >= 7'd32) || (flushing && pend != 7'd0));
	assign word = acc[word_w-1:0];  // Bits above pend are zero so padding comes for free

	assign field_bits = (({{word_w{1'b0}}, field_data} & (({{(2*word_w-1){1'b0}}, 1'b1} <<
		field_size) - 1'b1)) << pend);

	// ================================================
	// Accumulator update
	// ================================================
	// Push and take never meet since one needs pend at 32 or flushing and the other neither
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc      <= '0;
			pend     <= '0;
			flushing <= 1'b0;
		end else if (push) begin
			acc <= acc >> word_w;
			pend <= (pend >= 7'd32) ? pend - 7'd32 : 7'd0;
			if (flushing && pend <= 7'd32)
				flushing <= 1'b0;  // This push empties the packer
		end else if (take) begin
			acc  <= acc | field_bits;
			pend <= pend + {1'b0, field_size};
			if (field_last)
				flushing <= 1'b1;
		end
	end

	// Sizes outside 1 to 32 would corrupt the accumulator
	a_field_size: assert property (@(posedge clk) disable iff (!rst_n)
		field_valid |-> (field_size >= size_w'(1) && field_size <= size_w'(32)));

	// The sequencer must hold fields back while the packer is busy
	a_field_ready: assert property (@(posedge clk) disable iff (!rst_n)
		field_valid |-> pk_ready);

endmodule

//--- logic/stored_block_ctrl.sv
// Stored block sequencer

`timescale 1ns/1ps

module stored_block_ctrl import deflate_store_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	output logic              fifo_rd,
	input  logic [word_w-1:0] fifo_dout,
	input  logic              fifo_empty,
	input  logic              pk_ready,
	output logic              field_valid,
	output logic [size_w-1:0] field_size,
	output logic [word_w-1:0] field_data,
	output logic              field_last,
	output logic              crc_valid,
	output logic [byte_w-1:0] crc_byte,
	input  logic [word_w-1:0] crc_value,
	output logic              done,
	output logic              size_error
);

	// The four data states share bits 3:2 so bits 1:0 pick the byte
	localparam logic [3:0] st_idle   = 4'd0;
	localparam logic [3:0] st_header = 4'd1;
	localparam logic [3:0] st_len    = 4'd2;
	localparam logic [3:0] st_settle = 4'd3;
	localparam logic [3:0] st_data0  = 4'd4;
	localparam logic [3:0] st_data1  = 4'd5;
	localparam logic [3:0] st_data2  = 4'd6;
	localparam logic [3:0] st_data3  = 4'd7;
	localparam logic [3:0] st_crc    = 4'd8;
	localparam logic [3:0] st_isize  = 4'd9;

	logic [3:0]        state;
	logic [3:0]        state_nxt;
	header_word_t      in_word;          // Current FIFO word in its header or data view
	logic              block_final;      // BFINAL of the block in progress
	logic [15:0]       block_len;        // LEN of the block in progress
	logic [15:0]       byte_cnt;         // Data bytes taken so far in this block
	logic [15:0]       byte_cnt_nxt;
	logic              last_byte;
	logic [word_w-1:0] isize;            // Sum of LEN over all blocks
	logic              trailer_sent;     // ISIZE field is in the packer and waits on the flush
	logic              hdr_take;
	logic              byte_take;
	logic              set_done;

	assign in_word      = fifo_dout;
	assign byte_cnt_nxt = byte_cnt + 16'd1;
	assign last_byte    = (byte_cnt_nxt == block_len);

	// ================================================
	// Next state and field drive
	// ================================================
	always_comb begin
		state_nxt   = state;
		fifo_rd     = 1'b0;
		field_valid = 1'b0;
		field_size  = '0;
		field_data  = '0;
		field_last  = 1'b0;
		crc_byte    = '0;
		hdr_take    = 1'b0;
		byte_take   = 1'b0;
		set_done    = 1'b0;
		case (state)
			st_idle: begin
				// Fetch the next header unless the stream is closed
				if (!fifo_empty && !done) begin
					fifo_rd   = 1'b1;
					state_nxt = st_header;
				end
			end
			st_header: begin
				// BFINAL in bit 0 and BTYPE above it with padding to the byte boundary
				field_size = size_w'(8);
				field_data = word_w'({btype_stored, in_word.hdr.bfinal});
				if (pk_ready) begin
					field_valid = 1'b1;
					hdr_take    = 1'b1;
					state_nxt   = st_len;
				end
			end
			st_len: begin
				field_size = size_w'(32);
				field_data = {~block_len, block_len};  // LEN then NLEN with the low byte first
				// A nonempty block also needs its first data word fetched here
				if (pk_ready && (block_len == 16'd0 || !fifo_empty)) begin
					field_valid = 1'b1;
					if (block_len == 16'd0) begin
						state_nxt = block_final ? st_settle : st_idle;
					end else begin
						fifo_rd   = 1'b1;
						state_nxt = st_data0;
					end
				end
			end
			st_data0, st_data1, st_data2, st_data3: begin
				crc_byte   = in_word.bytes[state[1:0]];
				field_size = size_w'(8);
				field_data = word_w'(in_word.bytes[state[1:0]]);
				// Byte 3 also hands over to the next word unless the block ends
				if (pk_ready && (state != st_data3 || last_byte || !fifo_empty)) begin
					field_valid = 1'b1;
					byte_take   = 1'b1;
					if (last_byte) begin
						state_nxt = block_final ? st_settle : st_idle;
					end else if (state == st_data3) begin
						fifo_rd   = 1'b1;
						state_nxt = st_data0;
					end else begin
						state_nxt = state + 4'd1;
					end
				end
			end
			st_settle: state_nxt = st_crc;  // Last byte reaches the CRC register
			st_crc: begin
				field_size = size_w'(32);
				field_data = crc_value;
				if (pk_ready) begin
					field_valid = 1'b1;
					state_nxt   = st_isize;
				end
			end
			st_isize: begin
				field_size = size_w'(32);
				field_data = isize;
				field_last = 1'b1;
				if (pk_ready && !trailer_sent) begin
					field_valid = 1'b1;
				end else if (pk_ready) begin
					set_done  = 1'b1;      // Packer is ready again once the flush has gone out
					state_nxt = st_idle;
				end
			end
			default: state_nxt = st_idle;
		endcase
	end

	assign crc_valid = byte_take;  // CRC sees exactly the bytes the packer takes

	// ================================================
	// Block registers and status
	// ================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= st_idle;
			block_final  <= 1'b0;
			block_len    <= '0;
			byte_cnt     <= '0;
			isize        <= '0;
			trailer_sent <= 1'b0;
			done         <= 1'b0;
			size_error   <= 1'b0;
		end else begin
			state <= state_nxt;
			if (hdr_take) begin
				block_final <= in_word.hdr.bfinal;
				block_len   <= in_word.hdr.len;   // Low 16 bits even when len_hi is set
				byte_cnt    <= '0;
				isize       <= isize + word_w'(in_word.hdr.len);
				if ({in_word.hdr.len_hi, in_word.hdr.len} > 24'(max_stored_len))
					size_error <= 1'b1;
			end
			if (byte_take) byte_cnt <= byte_cnt_nxt;
			if (state == st_isize && field_valid) trailer_sent <= 1'b1;
			if (set_done) begin
				done         <= 1'b1;
				trailer_sent <= 1'b0;
			end
		end
	end

	// A data state always has at least one byte of the block left to take
	a_byte_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		(state[3:2] == 2'b01) |-> (byte_cnt < block_len));

endmodule

//--- logic/deflate_store_top.sv
// Deflate stored-mode framer

`timescale 1ns/1ps

module deflate_store_top import deflate_store_pkg::*; #(
	parameter int fifo_depth_log = 9
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_wr,        // Host writes only while in_full is low
	input  logic [word_w-1:0] in_data,
	output logic              in_full,
	input  logic              out_rd,       // Data follows one cycle later
	output logic [word_w-1:0] out_data,
	output logic              out_empty,
	output logic              done,
	output logic              size_error
);

	logic              fifo_rd;
	logic [word_w-1:0] fifo_dout;
	logic              fifo_empty;
	logic              pk_ready;
	logic              field_valid;
	logic [size_w-1:0] field_size;
	logic [word_w-1:0] field_data;
	logic              field_last;
	logic              crc_valid;
	logic [byte_w-1:0] crc_byte;
	logic [word_w-1:0] crc_value;
	logic              push;
	logic [word_w-1:0] pk_word;
	logic              out_full;

	// ================================================
	// Input side
	// ================================================
	word_fifo #(.fifo_depth_log(fifo_depth_log)) u_in_fifo (
		.clk(clk), .rst_n(rst_n), .wr(in_wr), .din(in_data), .full(in_full),
		.rd(fifo_rd), .dout(fifo_dout), .empty(fifo_empty));

	stored_block_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .fifo_rd(fifo_rd), .fifo_dout(fifo_dout),
		.fifo_empty(fifo_empty), .pk_ready(pk_ready), .field_valid(field_valid),
		.field_size(field_size), .field_data(field_data), .field_last(field_last),
		.crc_valid(crc_valid), .crc_byte(crc_byte), .crc_value(crc_value),
		.done(done), .size_error(size_error));

	crc32_engine u_crc (
		.clk(clk), .rst_n(rst_n), .crc_valid(crc_valid), .crc_byte(crc_byte),
		.crc_value(crc_value));

	// ================================================
	// Output side
	// ================================================
	bit_packer u_packer (
		.clk(clk), .rst_n(rst_n), .field_valid(field_valid), .field_size(field_size),
		.field_data(field_data), .field_last(field_last), .pk_ready(pk_ready),
		.out_full(out_full), .push(push), .word(pk_word));

	word_fifo #(.fifo_depth_log(fifo_depth_log)) u_out_fifo (
		.clk(clk), .rst_n(rst_n), .wr(push), .din(pk_word), .full(out_full),
		.rd(out_rd), .dout(out_data), .empty(out_empty));

endmodule

//--- verification/deflate_model.sv
// Stored stream reference model

`timescale 1ns/1ps

module deflate_model;

	localparam logic [31:0] poly     = 32'hEDB88320;  // Reflected CRC32 polynomial
	localparam logic [31:0] all_ones = 32'hFFFFFFFF;  // CRC start value and final XOR

	logic [7:0]  stream [$];  // Expected byte stream with the oldest byte first
	logic [31:0] words  [$];  // The same stream packed four bytes to a word
	logic [31:0] crc_reg;     // Running remainder over all data bytes
	logic [31:0] total_len;   // ISIZE as the sum of LEN over the blocks

	task automatic start_stream();
		stream.delete();
		words.delete();
		crc_reg   = all_ones;
		total_len = '0;
	endtask

	// Header byte followed by LEN and NLEN with the low byte first
	task automatic add_header(input logic bfinal, input logic [15:0] len);
		stream.push_back({5'd0, 2'b00, bfinal});  // BTYPE 00 sits above BFINAL
		stream.push_back(len[7:0]);
		stream.push_back(len[15:8]);
		stream.push_back(~len[7:0]);
		stream.push_back(~len[15:8]);
		total_len = total_len + {16'd0, len};
	endtask

	// One bit at a time with the LSB of the byte first as in the gzip definition
	task automatic add_byte(input logic [7:0] b);
		logic fb;
		stream.push_back(b);
		for (int i = 0; i < 8; i++) begin
			fb      = crc_reg[0] ^ b[i];  // Feedback bit
			crc_reg = crc_reg >> 1;
			if (fb)
				crc_reg = crc_reg ^ poly;
		end
	endtask

	// ================================================
	// Trailer and word packing
	// ================================================
	task automatic close_stream();
		logic [31:0] crc_out;
		logic [31:0] w;
		crc_out = crc_reg ^ all_ones;
		for (int k = 0; k < 4; k++)
			stream.push_back(crc_out[8*k +: 8]);
		for (int k = 0; k < 4; k++)
			stream.push_back(total_len[8*k +: 8]);
		for (int i = 0; i < stream.size(); i += 4) begin
			w = '0;                                  // Missing bytes stay zero
			for (int k = 0; k < 4; k++) begin
				if (i + k < stream.size())
					w[8*k +: 8] = stream[i + k];     // Low byte goes out first
			end
			words.push_back(w);
		end
	endtask

	function automatic int word_count();
		return words.size();
	endfunction

	function automatic logic [31:0] word_at(input int idx);
		return words[idx];
	endfunction

endmodule

//--- verification/tb_deflate_store.sv
// Deflate stored framer testbench

`timescale 1ns/1ps

module tb_deflate_store;

	localparam int num_tests  = 8;
	localparam int max_blocks = 4;
	localparam int max_len    = 40;

	logic        clk;
	logic        rst_n;
	logic        in_wr;
	logic [31:0] in_data;
	logic        in_full;
	logic        out_rd;
	logic [31:0] out_data;
	logic        out_empty;
	logic        done;
	logic        size_error;

	integer      seed;
	int          blk_cnt [num_tests];              // Blocks per test
	int          blk_len [num_tests][max_blocks];  // LEN of each block
	logic [7:0]  blk_hi  [num_tests][max_blocks];  // len_hi which is nonzero only in the error test
	logic [31:0] in_words [$];                     // Input word stream of the current test
	logic        exp_err;
	int          cur_test;
	int          got_words;
	int          test_errors;
	int          errors;
	int          passed;
	int          limit_cycles;
	bit          limit_ready;

	// Small FIFOs so both full flags are reached
	deflate_store_top #(.fifo_depth_log(3)) u_deflate_store_top (
		.clk(clk), .rst_n(rst_n), .in_wr(in_wr), .in_data(in_data), .in_full(in_full),
		.out_rd(out_rd), .out_data(out_data), .out_empty(out_empty), .done(done),
		.size_error(size_error));

	deflate_model u_model ();

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(($random(seed) & 32'h7FFF_FFFF) % (hi - lo + 1));
	endfunction

	task automatic reset_dut();
		rst_n  = 1'b0;
		in_wr  = 1'b0;
		out_rd = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (!done && !size_error && out_empty && !in_full) else begin
			$display("[FAIL] time %0t: status flags not clear after reset in test %0d", $time,
				cur_test);
			test_errors++;
		end
	endtask

	// Header word followed by data words with random filler past LEN
	task automatic build_test(input int t);
		logic        bfinal;
		logic [31:0] w;
		logic [7:0]  b;
		in_words.delete();
		u_model.start_stream();
		exp_err = 1'b0;
		for (int k = 0; k < blk_cnt[t]; k++) begin
			bfinal = (k == blk_cnt[t] - 1);  // Only the last block is final
			in_words.push_back({7'd0, bfinal, blk_hi[t][k], 16'(blk_len[t][k])});
			u_model.add_header(bfinal, 16'(blk_len[t][k]));
			if (blk_hi[t][k] != 8'd0)
				exp_err = 1'b1;
			for (int i = 0; i < blk_len[t][k]; i += 4) begin
				for (int j = 0; j < 4; j++) begin
					b = 8'($random(seed));
					w[8*j +: 8] = b;
					if (i + j < blk_len[t][k])
						u_model.add_byte(b);
				end
				in_words.push_back(w);
			end
		end
		u_model.close_stream();
	endtask

	task automatic send_words();
		int idx;
		idx = 0;
		while (idx < in_words.size()) begin
			@(negedge clk);
			in_wr = !in_full;  // Host holds off while the input FIFO is full
			if (!in_full) begin
				in_data = in_words[idx];
				idx++;
			end
		end
		@(negedge clk);
		in_wr = 1'b0;
	endtask

	// ================================================
	// Output side and status checks
	// ================================================
	task automatic collect_words(input int hold);
		int          exp_n;
		int          cyc;
		bit          pending;   // A read was issued at the previous falling edge
		bit          done_seen;
		logic [31:0] rnd;
		exp_n     = u_model.word_count();
		got_words = 0;
		pending   = 1'b0;
		done_seen = 1'b0;
		cyc       = 0;
		while (got_words < exp_n) begin
			@(negedge clk);
			cyc++;
			if (pending) begin
				assert (out_data === u_model.word_at(got_words)) else begin
					$display("[FAIL] time %0t: test %0d word %0d is %h, expected %h", $time,
						cur_test, got_words, out_data, u_model.word_at(got_words));
					test_errors++;
				end
				got_words++;
			end
			// Unread trailer words must still sit in the output FIFO once done is up
			assert (!(done && got_words < exp_n && out_empty)) else begin
				$display("[FAIL] time %0t: done high with only %0d of %0d words out", $time,
					got_words, exp_n);
				test_errors++;
			end
			assert (!(done_seen && !done)) else begin
				$display("[FAIL] time %0t: done fell in test %0d", $time, cur_test);
				test_errors++;
			end
			done_seen = done_seen | done;
			rnd       = $random(seed);
			out_rd    = !out_empty && (got_words < exp_n) && (cyc > hold) && rnd[0];
			pending   = out_rd;
		end
		out_rd = 1'b0;
		while (!done)
			@(negedge clk);
		assert (out_empty) else begin
			$display("[FAIL] time %0t: extra output words after the trailer in test %0d", $time,
				cur_test);
			test_errors++;
		end
		assert (size_error == exp_err) else begin
			$display("[FAIL] time %0t: size_error is %b, expected %b", $time, size_error, exp_err);
			test_errors++;
		end
	endtask

	// Limit grows with the total number of data bytes over all tests
	initial begin
		wait (limit_ready);
		repeat (limit_cycles) @(posedge clk);
		$display("Run timed out after %0d cycles, the DUT stopped making progress", limit_cycles);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int total;
		seed        = 32'h5b43d73b;
		rst_n       = 1'b0;
		in_wr       = 1'b0;
		in_data     = '0;
		out_rd      = 1'b0;
		errors      = 0;
		passed      = 0;
		total       = 0;
		limit_ready = 1'b0;
		for (int t = 0; t < num_tests; t++) begin
			case (t)
				0: blk_cnt[t] = 1;                  // Single final block
				1: blk_cnt[t] = rand_range(2, max_blocks);
				2, 3: blk_cnt[t] = 3;               // Zero lengths and back-pressure
				4: blk_cnt[t] = 2;                  // Oversized header
				default: blk_cnt[t] = rand_range(1, max_blocks);
			endcase
			for (int b = 0; b < max_blocks; b++) begin
				blk_len[t][b] = (t == 3) ? rand_range(20, max_len) : rand_range(0, max_len);
				blk_hi[t][b]  = 8'd0;
			end
		end
		blk_len[0][0] = rand_range(1, max_len);
		blk_len[2][0] = 0;  // Non-final empty block
		blk_len[2][2] = 0;  // Final empty block
		blk_hi[4][0]  = 8'(rand_range(1, 255));
		for (int t = 0; t < num_tests; t++) begin
			for (int b = 0; b < blk_cnt[t]; b++)
				total += blk_len[t][b];
		end
		limit_cycles = 200 * total + 2000;
		limit_ready  = 1'b1;

		for (int t = 0; t < num_tests; t++) begin
			cur_test    = t;
			test_errors = 0;
			reset_dut();
			build_test(t);
			fork
				send_words();
				collect_words((t == 3) ? 120 : 0);  // Test 3 lets the output FIFO fill
			join
			errors += test_errors;
			if (test_errors == 0)
				passed++;
			$display("Test %0d: %0d blocks, %0d words, %0d errors", t, blk_cnt[t],
				got_words, test_errors);
		end
		$display("%0d of %0d tests correct, %0d errors", passed, num_tests, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- deflate_store.f
logic/deflate_store_pkg.sv
logic/word_fifo.sv
logic/crc32_engine.sv
logic/bit_packer.sv
logic/stored_block_ctrl.sv
logic/deflate_store_top.sv
verification/deflate_model.sv
verification/tb_deflate_store.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the deflate_store testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Mdir obj_dir --top-module tb_deflate_store -f deflate_store.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_deflate_store > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" "$log"; then
	exit 0
fi
exit 1
